// ==== compile.f ====
+incdir+source
source/mipsPkg.sv
source/cpuControl.sv
source/registerFile.sv
source/aluUnit.sv
source/busMaster.sv
source/mipsCpuBus.sv
verification/cpuChecker.sv
verification/tbMipsCpuBus.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tbMipsCpuBus -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module aluUnit (
    input  wire mipsPkg::instrFields_t fields,
    input  wire mipsPkg::word_t        pc,
    input  wire mipsPkg::word_t        rsValue,
    input  wire mipsPkg::word_t        rtValue,
    output mipsPkg::execResult_t       result
);

    import mipsPkg::*;

    word_t  signImm;
    word_t  zeroImm;
    word_t  pcPlus4;
    word_t  branchTarget;
    word_t  jumpTarget;
    shamt_t varShift;

    assign signImm      = {{16{fields.immediate[15]}}, fields.immediate};
    assign zeroImm      = {16'h0000, fields.immediate};
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
    // 26-bit index spans rs, rt and the immediate
    assign jumpTarget   = {pcPlus4[31:28], fields.rs, fields.rt, fields.immediate, 2'b00};
    assign varShift     = rsValue[4:0];

    always_comb begin
        result = '0;
        case (fields.opcode)
            OPC_SPECIAL: begin
                result.dest     = fields.rd;
                result.regWrite = 1'b1;
                case (fields.funct)
                    FN_ADDU: result.aluResult = rsValue + rtValue;
                    FN_SUBU: result.aluResult = rsValue - rtValue;
                    FN_AND:  result.aluResult = rsValue & rtValue;
                    FN_OR:   result.aluResult = rsValue | rtValue;
                    FN_XOR:  result.aluResult = rsValue ^ rtValue;
                    FN_SLT:  result.aluResult = {31'd0, $signed(rsValue) < $signed(rtValue)};
                    FN_SLTU: result.aluResult = {31'd0, rsValue < rtValue};
                    FN_SLL:  result.aluResult = rtValue << fields.shamt;
                    FN_SRL:  result.aluResult = rtValue >> fields.shamt;
                    FN_SRA:  result.aluResult = $signed(rtValue) >>> fields.shamt;
                    FN_SLLV: result.aluResult = rtValue << varShift;
                    FN_SRLV: result.aluResult = rtValue >> varShift;
                    FN_SRAV: result.aluResult = $signed(rtValue) >>> varShift;
                    FN_JR: begin
                        result.regWrite    = 1'b0;
                        result.branchTaken = 1'b1;
                        result.target      = rsValue;
                        result.halt        = (rsValue == `CPU_HALT_ADDRESS);
                    end
                    default: result.regWrite = 1'b0;
                endcase
            end
            OPC_J: begin
                result.branchTaken = 1'b1;
                result.target      = jumpTarget;
            end
            OPC_BEQ, OPC_BNE: begin
                result.target      = branchTarget;
                result.branchTaken = (rsValue == rtValue) ^ (fields.opcode == OPC_BNE);
            end
            OPC_LW: begin
                result.aluResult = rsValue + signImm;
                result.dest      = fields.rt;
                result.regWrite  = 1'b1;
                result.load      = 1'b1;
            end
            OPC_SW: begin
                result.aluResult = rsValue + signImm;
                result.store     = 1'b1;
            end
            default: begin
                // Remaining I-type ALU ops write rt
                result.dest     = fields.rt;
                result.regWrite = 1'b1;
                case (fields.opcode)
                    OPC_ADDIU: result.aluResult = rsValue + signImm;
                    OPC_SLTI:  result.aluResult = {31'd0, $signed(rsValue) < $signed(signImm)};
                    OPC_SLTIU: result.aluResult = {31'd0, rsValue < signImm};
                    OPC_ANDI:  result.aluResult = rsValue & zeroImm;
                    OPC_ORI:   result.aluResult = rsValue | zeroImm;
                    OPC_XORI:  result.aluResult = rsValue ^ zeroImm;
                    OPC_LUI:   result.aluResult = {fields.immediate, 16'h0000};
                    default: begin
                        result.dest     = '0;
                        result.regWrite = 1'b0;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/busMaster.sv ====
`timescale 1ns/1ps
`default_nettype none

module busMaster (
    input  wire                        clk,
    input  wire                        reset,
    input  wire mipsPkg::busRequest_t  request,
    input  wire                        waitrequest,
    output mipsPkg::word_t             address,
    output logic                       read,
    output logic                       write,
    output mipsPkg::word_t             writedata,
    output logic [3:0]                 byteenable,
    input  wire mipsPkg::word_t        readdata,
    output mipsPkg::word_t             readWord,
    output logic                       transferDone
);

    import mipsPkg::*;

    // Little-endian memory against the big-endian word view of the core
    function automatic word_t swapBytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign address    = request.address;
    assign read       = request.read;
    assign write      = request.write;
    assign writedata  = swapBytes(request.writeData);
    assign readWord   = swapBytes(readdata);

    // Whole-word accesses only
    assign byteenable = 4'b1111;

    // Slave accepts on the edge where waitrequest is low
    assign transferDone = (request.read || request.write) && !waitrequest;

    holdDuringWait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("bus request changed while waitrequest was high");

endmodule

`default_nettype wire

// ==== source/cpuControl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuControl (
    input  wire                        clk,
    input  wire                        reset,
    output logic                       active,
    input  wire mipsPkg::word_t        instrWord,
    input  wire                        transferDone,
    input  wire mipsPkg::execResult_t  result,
    output mipsPkg::busRequest_t       busReq,
    output mipsPkg::instrFields_t      fields,
    output mipsPkg::word_t             pc,
    output logic                       regWriteEnable,
    output mipsPkg::regIndex_t         regWriteIndex,
    output mipsPkg::word_t             regWriteData,
    input  wire mipsPkg::word_t        rtValue
);

    import mipsPkg::*;

    cpuState_t   state;
    cpuState_t   nextState;
    word_t       instrReg;
    word_t       loadWord;
    execResult_t execReg;
    word_t       nextPc;
    word_t       delayTarget;
    logic        delayPending;
    logic        haltPending;
    logic        instrDone;

    // Instruction register split into its fields
    assign fields = '{
        opcode:    opcode_t'(instrReg[31:26]),
        rs:        instrReg[25:21],
        rt:        instrReg[20:16],
        rd:        instrReg[15:11],
        shamt:     instrReg[10:6],
        funct:     funct_t'(instrReg[5:0]),
        immediate: instrReg[15:0]
    };

    // A branch taken by the previous instruction redirects after this one
    assign nextPc = delayPending ? delayTarget : pc + 32'd4;

    always_comb begin
        nextState = state;
        instrDone = 1'b0;
        case (state)
            FETCH: begin
                if (transferDone) begin
                    nextState = DECODE;
                end
            end
            DECODE: begin
                nextState = EXECUTE;
            end
            EXECUTE: begin
                if (result.load || result.store) begin
                    nextState = MEMORY;
                end else if (result.regWrite) begin
                    nextState = WRITEBACK;
                end else begin
                    // Branches, jumps and unknown opcodes end here
                    instrDone = 1'b1;
                end
            end
            MEMORY: begin
                if (transferDone) begin
                    if (execReg.load) begin
                        nextState = WRITEBACK;
                    end else begin
                        instrDone = 1'b1;
                    end
                end
            end
            WRITEBACK: begin
                instrDone = 1'b1;
            end
            default: begin
                nextState = HALT;
            end
        endcase
        // Halting jump stops once its delay slot has retired
        if (instrDone) begin
            nextState = haltPending ? HALT : FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= FETCH;
            active       <= 1'b0;
            pc           <= `CPU_RESET_VECTOR;
            delayPending <= 1'b0;
            haltPending  <= 1'b0;
        end else begin
            state  <= nextState;
            active <= (nextState != HALT);
            if (instrDone) begin
                pc           <= nextPc;
                delayPending <= (state == EXECUTE) && result.branchTaken;
                haltPending  <= (state == EXECUTE) && result.halt;
            end
        end
    end

    // Bus read data serves both the instruction and the load word
    always_ff @(posedge clk) begin
        if ((state == FETCH) && transferDone) begin
            instrReg <= instrWord;
        end
        if ((state == MEMORY) && transferDone) begin
            loadWord <= instrWord;
        end
        if (state == EXECUTE) begin
            execReg <= result;
            if (result.branchTaken) begin
                delayTarget <= result.target;
            end
        end
    end

    always_comb begin
        busReq.read      = active && ((state == FETCH) || ((state == MEMORY) && execReg.load));
        busReq.write     = active && (state == MEMORY) && execReg.store;
        busReq.address   = (state == MEMORY) ? execReg.aluResult : pc;
        busReq.writeData = rtValue;
    end

    // Register write happens only on the WRITEBACK edge
    assign regWriteEnable = (state == WRITEBACK);
    assign regWriteIndex  = execReg.dest;
    assign regWriteData   = execReg.load ? loadWord : execReg.aluResult;

    oneStrobe: assert property (@(posedge clk) disable iff (reset)
        !(busReq.read && busReq.write))
        else $error("read and write strobes active together");

    haltSticky: assert property (@(posedge clk) disable iff (reset)
        (state == HALT) |=> (state == HALT))
        else $error("state left HALT without reset");

endmodule

`default_nettype wire

// ==== source/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Boot address taken on reset
`define CPU_RESET_VECTOR 32'hBFC0_0000

// JR to this address stops the processor after its delay slot
`define CPU_HALT_ADDRESS 32'h0000_0000

// General purpose registers, r0 included
`define CPU_REG_COUNT 32

`endif

// ==== source/mipsCpuBus.sv ====
`timescale 1ns/1ps
`default_nettype none

module mipsCpuBus (
    input  wire                  clk,
    input  wire                  reset,
    output logic                 active,
    output mipsPkg::word_t       registerV0,
    output mipsPkg::word_t       address,
    output logic                 write,
    output logic                 read,
    input  wire                  waitrequest,
    output mipsPkg::word_t       writedata,
    output logic [3:0]           byteenable,
    input  wire mipsPkg::word_t  readdata
);

    import mipsPkg::*;

    busRequest_t  busReq;
    word_t        readWord;
    logic         transferDone;
    execResult_t  result;
    instrFields_t fields;
    word_t        pc;
    logic         regWriteEnable;
    regIndex_t    regWriteIndex;
    word_t        regWriteData;
    word_t        rsValue;
    word_t        rtValue;

    cpuControl control (
        .clk            (clk),
        .reset          (reset),
        .active         (active),
        .instrWord      (readWord),
        .transferDone   (transferDone),
        .result         (result),
        .busReq         (busReq),
        .fields         (fields),
        .pc             (pc),
        .regWriteEnable (regWriteEnable),
        .regWriteIndex  (regWriteIndex),
        .regWriteData   (regWriteData),
        .rtValue        (rtValue)
    );

    registerFile regFile (
        .clk         (clk),
        .reset       (reset),
        .rsIndex     (fields.rs),
        .rtIndex     (fields.rt),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .writeEnable (regWriteEnable),
        .writeIndex  (regWriteIndex),
        .writeData   (regWriteData),
        .v0          (registerV0)
    );

    aluUnit alu (
        .fields  (fields),
        .pc      (pc),
        .rsValue (rsValue),
        .rtValue (rtValue),
        .result  (result)
    );

    busMaster bus (
        .clk          (clk),
        .reset        (reset),
        .request      (busReq),
        .waitrequest  (waitrequest),
        .address      (address),
        .read         (read),
        .write        (write),
        .writedata    (writedata),
        .byteenable   (byteenable),
        .readdata     (readdata),
        .readWord     (readWord),
        .transferDone (transferDone)
    );

endmodule

`default_nettype wire

// ==== source/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIndex_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    // Major opcodes of the supported subset
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'd0,
        OPC_J       = 6'd2,
        OPC_BEQ     = 6'd4,
        OPC_BNE     = 6'd5,
        OPC_ADDIU   = 6'd9,
        OPC_SLTI    = 6'd10,
        OPC_SLTIU   = 6'd11,
        OPC_ANDI    = 6'd12,
        OPC_ORI     = 6'd13,
        OPC_XORI    = 6'd14,
        OPC_LUI     = 6'd15,
        OPC_LW      = 6'd35,
        OPC_SW      = 6'd43
    } opcode_t;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALT
    } cpuState_t;

    // Decoded view of the instruction register
    typedef struct packed {
        opcode_t   opcode;
        regIndex_t rs;
        regIndex_t rt;
        regIndex_t rd;
        shamt_t    shamt;
        funct_t    funct;
        imm_t      immediate;
    } instrFields_t;

    // aluResult doubles as the effective address for loads and stores
    typedef struct packed {
        word_t     aluResult;
        regIndex_t dest;
        logic      regWrite;
        logic      load;
        logic      store;
        logic      branchTaken;
        logic      halt;
        word_t     target;
    } execResult_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t address;
        word_t writeData;
    } busRequest_t;

endpackage

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module registerFile (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mipsPkg::regIndex_t  rsIndex,
    input  wire mipsPkg::regIndex_t  rtIndex,
    output mipsPkg::word_t           rsValue,
    output mipsPkg::word_t           rtValue,
    input  wire                      writeEnable,
    input  wire mipsPkg::regIndex_t  writeIndex,
    input  wire mipsPkg::word_t      writeData,
    output mipsPkg::word_t           v0
);

    import mipsPkg::*;

    // Result register of the calling convention
    localparam regIndex_t V0_INDEX = 5'd2;

    word_t regs [`CPU_REG_COUNT];

    assign rsValue = regs[rsIndex];
    assign rtValue = regs[rtIndex];
    assign v0      = regs[V0_INDEX];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeIndex != '0)) begin
            regs[writeIndex] <= writeData;
        end
    end

    zeroReadsZero: assert property (@(posedge clk) disable iff (reset)
        ((rsIndex == '0) -> (rsValue == '0)) && ((rtIndex == '0) -> (rtValue == '0)))
        else $error("register zero read back nonzero");

endmodule

`default_nettype wire

// ==== verification/cpuChecker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuChecker (
    input wire                 clk,
    input wire                 reset,
    input wire                 active,
    input wire mipsPkg::word_t registerV0,
    input wire mipsPkg::word_t address,
    input wire                 read,
    input wire                 write,
    input wire                 waitrequest,
    input wire mipsPkg::word_t writedata,
    input wire [3:0]           byteenable
);

    import mipsPkg::*;

    string testName;
    word_t expAddr [$];
    word_t expData [$];
    word_t expV0;
    int    testErrors  = 0;
    int    errorCount  = 0;
    int    testsRun    = 0;
    int    testsFailed = 0;
    logic  running     = 1'b0;
    logic  testDone    = 1'b0;
    logic  halted      = 1'b0;
    logic  sawRead     = 1'b0;
    logic  wasActive   = 1'b0;
    logic  holdPending = 1'b0;
    word_t heldAddress = '0;

    function automatic word_t fromMemoryOrder(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Instruction-level model of the subset including delay slots
    function automatic void runReference(input word_t image [$]);
        word_t regs [`CPU_REG_COUNT];
        word_t dmem [word_t];
        word_t pc, target, newTarget, nextPc, instr, rs, rt, simm, res, ea;
        logic pending, newPending, haltNext, stopNow, wr;
        logic [4:0] dest;
        int idx;
        expAddr.delete();
        expData.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc       = `CPU_RESET_VECTOR;
        target   = '0;
        pending  = 1'b0;
        haltNext = 1'b0;
        for (int step = 0; step < 1000; step++) begin
            idx = int'((pc - `CPU_RESET_VECTOR) >> 2);
            instr = ((idx >= 0) && (idx < image.size())) ? image[idx] : '0;
            rs = regs[instr[25:21]];
            rt = regs[instr[20:16]];
            simm = {{16{instr[15]}}, instr[15:0]};
            ea = rs + simm;
            stopNow = haltNext;
            nextPc = pending ? target : pc + 32'd4;
            newPending = 1'b0;
            newTarget = '0;
            res = '0;
            dest = instr[20:16];
            wr = 1'b1;
            case (instr[31:26])
                6'd0: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        6'd33: res = rs + rt;
                        6'd35: res = rs - rt;
                        6'd36: res = rs & rt;
                        6'd37: res = rs | rt;
                        6'd38: res = rs ^ rt;
                        6'd42: res = {31'd0, $signed(rs) < $signed(rt)};
                        6'd43: res = {31'd0, rs < rt};
                        6'd0:  res = rt << instr[10:6];
                        6'd2:  res = rt >> instr[10:6];
                        6'd3:  res = word_t'($signed(rt) >>> instr[10:6]);
                        6'd4:  res = rt << rs[4:0];
                        6'd6:  res = rt >> rs[4:0];
                        6'd7:  res = word_t'($signed(rt) >>> rs[4:0]);
                        6'd8: begin
                            wr = 1'b0;
                            newPending = 1'b1;
                            newTarget = rs;
                            haltNext = (rs == `CPU_HALT_ADDRESS);
                        end
                        default: wr = 1'b0;
                    endcase
                end
                6'd2: begin
                    wr = 1'b0;
                    newPending = 1'b1;
                    newTarget = pc + 32'd4;
                    newTarget = {newTarget[31:28], instr[25:0], 2'b00};
                end
                6'd4, 6'd5: begin
                    wr = 1'b0;
                    newPending = (rs == rt) ^ instr[26];
                    newTarget = pc + 32'd4 + (simm << 2);
                end
                6'd9:  res = ea;
                6'd10: res = {31'd0, $signed(rs) < $signed(simm)};
                6'd11: res = {31'd0, rs < simm};
                6'd12: res = rs & {16'd0, instr[15:0]};
                6'd13: res = rs | {16'd0, instr[15:0]};
                6'd14: res = rs ^ {16'd0, instr[15:0]};
                6'd15: res = {instr[15:0], 16'd0};
                6'd35: res = dmem.exists(ea) ? dmem[ea] : '0;
                6'd43: begin
                    wr = 1'b0;
                    dmem[ea] = rt;
                    expAddr.push_back(ea);
                    expData.push_back(rt);
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dest != 5'd0)) begin
                regs[dest] = res;
            end
            pending = newPending;
            if (newPending) begin
                target = newTarget;
            end
            pc = nextPc;
            if (stopNow) begin
                break;
            end
        end
        expV0 = regs[2];
    endfunction

    task automatic noteMismatch(input string what, input word_t expected, input word_t actual);
        $display("mismatch %s %s expected %h actual %h", testName, what, expected, actual);
        testErrors++;
        errorCount++;
    endtask

    task automatic noteFailure(input string msg);
        $display("error in %s: %s", testName, msg);
        testErrors++;
        errorCount++;
    endtask

    task automatic startTest(input string name, input word_t image [$]);
        testName   = name;
        runReference(image);
        testErrors = 0;
        testDone   = 1'b0;
        halted     = 1'b0;
        sawRead    = 1'b0;
        running    = 1'b1;
    endtask

    task automatic finishTest();
        running = 1'b0;
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: ok", testName);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", testName, testErrors);
        end
    endtask

    always @(posedge clk) begin
        if (reset || !running) begin
            wasActive   = 1'b0;
            holdPending = 1'b0;
        end else begin
            if ((read || write) && (byteenable != 4'hF)) begin
                noteFailure("byteenable is not all ones");
            end
            if (holdPending && (address != heldAddress)) begin
                noteFailure("bus address changed during waitrequest");
            end
            if (halted && (read || write)) begin
                noteFailure("bus traffic after halt");
            end
            if (read && !sawRead) begin
                sawRead = 1'b1;
                if (address != `CPU_RESET_VECTOR) begin
                    noteMismatch("first fetch address", `CPU_RESET_VECTOR, address);
                end
            end
            if (write && !waitrequest) begin
                if (expAddr.size() == 0) begin
                    noteFailure("store not expected by the reference");
                end else begin
                    if (address != expAddr[0]) begin
                        noteMismatch("store address", expAddr[0], address);
                    end
                    if (fromMemoryOrder(writedata) != expData[0]) begin
                        noteMismatch("store data", expData[0], fromMemoryOrder(writedata));
                    end
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                end
            end
            if (wasActive && !active && !halted) begin
                halted = 1'b1;
                if (registerV0 != expV0) begin
                    noteMismatch("final v0", expV0, registerV0);
                end
                if (expAddr.size() != 0) begin
                    noteFailure("halted before all expected stores");
                end
                testDone = 1'b1;
            end
            wasActive   = active;
            holdPending = (read || write) && waitrequest;
            heldAddress = address;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tbMipsCpuBus.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module tbMipsCpuBus;

    import mipsPkg::*;

    localparam int NUM_TESTS   = 4;
    localparam int CYCLE_LIMIT = 2000 * NUM_TESTS;

    logic  clk;
    logic  reset;
    logic  waitrequest;
    word_t readdata;
    logic  active;
    word_t registerV0;
    word_t address;
    logic  write;
    logic  read;
    word_t writedata;
    logic  [3:0] byteenable;

    word_t mem [word_t];
    word_t prog [$];
    word_t lcgState = 32'he114_abea;
    int    cycles = 0;

    mipsCpuBus dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .registerV0  (registerV0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    cpuChecker scoreboard (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .registerV0  (registerV0),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic word_t toMemoryOrder(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic word_t encR(input logic [5:0] fn, input regIndex_t rd, input regIndex_t rs,
                                   input regIndex_t rt, input shamt_t sa);
        return {6'd0, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t encI(input logic [5:0] op, input regIndex_t rt, input regIndex_t rs,
                                   input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encJ(input word_t target);
        return {6'd2, target[27:2]};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic loadConst(input regIndex_t r, input word_t value);
        emit(encI(OPC_LUI, r, 5'd0, value[31:16]));
        emit(encI(OPC_ORI, r, r, value[15:0]));
    endtask

    // JR to the halt address plus its delay slot
    task automatic emitHalt();
        emit(encR(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
        emit(32'h0000_0000);
    endtask

    // Slave model with one wait cycle minimum and random stalls
    always @(posedge clk) begin
        word_t r;
        r = nextRandom();
        if (reset) begin
            waitrequest <= 1'b1;
        end else if ((read || write) && waitrequest && (r[17:16] != 2'b00)) begin
            waitrequest <= 1'b0;
            if (write) begin
                mem[address] = writedata;
            end
            readdata <= mem.exists(address) ? mem[address] : '0;
        end else begin
            waitrequest <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic runProgram(input string name);
        mem.delete();
        foreach (prog[i]) begin
            mem[`CPU_RESET_VECTOR + 32'(4 * i)] = toMemoryOrder(prog[i]);
        end
        @(posedge clk);
        reset <= 1'b1;
        scoreboard.startTest(name, prog);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        while (!scoreboard.testDone) begin
            @(posedge clk);
        end
        // Watch the bus a while after halt
        repeat (20) @(posedge clk);
        scoreboard.finishTest();
        @(negedge clk);
    endtask

    task automatic buildRtype();
        funct_t fns [13];
        fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU,
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
        prog.delete();
        loadConst(5'd8, nextRandom());
        loadConst(5'd9, nextRandom());
        emit(encI(OPC_LUI, 5'd20, 5'd0, 16'h1000));
        for (int k = 0; k < 13; k++) begin
            emit(encR(fns[k], 5'd10, 5'd8, 5'd9, shamt_t'(3 * k + 1)));
            emit(encI(OPC_SW, 5'd10, 5'd20, imm_t'(4 * k)));
        end
        emitHalt();
    endtask

    task automatic buildItype();
        word_t r;
        prog.delete();
        r = nextRandom();
        loadConst(5'd8, nextRandom());
        emit(encI(OPC_ADDIU, 5'd2, 5'd8, r[15:0] | 16'h8000));
        emit(encI(OPC_ANDI, 5'd3, 5'd8, r[31:16] | 16'h8000));
        emit(encI(OPC_ORI, 5'd4, 5'd8, 16'hF00F));
        emit(encI(OPC_XORI, 5'd5, 5'd8, r[23:8]));
        emit(encI(OPC_SLTI, 5'd6, 5'd8, 16'hFF00));
        emit(encI(OPC_SLTIU, 5'd7, 5'd8, 16'h8001));
        emit(encI(OPC_LUI, 5'd9, 5'd0, 16'hBEEF));
        emit(encR(FN_ADDU, 5'd2, 5'd2, 5'd3, 5'd0));
        emit(encR(FN_XOR, 5'd2, 5'd2, 5'd4, 5'd0));
        emit(encR(FN_ADDU, 5'd2, 5'd2, 5'd5, 5'd0));
        emit(encR(FN_SLL, 5'd6, 5'd0, 5'd6, 5'd4));
        emit(encR(FN_SLL, 5'd7, 5'd0, 5'd7, 5'd8));
        emit(encR(FN_OR, 5'd2, 5'd2, 5'd6, 5'd0));
        emit(encR(FN_ADDU, 5'd2, 5'd2, 5'd7, 5'd0));
        emit(encR(FN_XOR, 5'd2, 5'd2, 5'd9, 5'd0));
        emitHalt();
    endtask

    task automatic buildMemory();
        prog.delete();
        loadConst(5'd8, nextRandom());
        loadConst(5'd9, nextRandom());
        emit(encI(OPC_LUI, 5'd20, 5'd0, 16'h2000));
        emit(encI(OPC_SW, 5'd8, 5'd20, 16'h0000));
        emit(encI(OPC_SW, 5'd9, 5'd20, 16'hFFFC));
        emit(encI(OPC_LW, 5'd2, 5'd20, 16'h0000));
        emit(encI(OPC_LW, 5'd3, 5'd20, 16'hFFFC));
        emit(encR(FN_SUBU, 5'd2, 5'd2, 5'd3, 5'd0));
        emit(encI(OPC_SW, 5'd2, 5'd20, 16'h0008));
        emit(encI(OPC_LW, 5'd4, 5'd20, 16'h0008));
        emit(encR(FN_ADDU, 5'd2, 5'd2, 5'd4, 5'd0));
        emitHalt();
    endtask

    // Word offsets from the program start mark the branch and jump targets
    task automatic buildBranch();
        prog.delete();
        emit(encI(OPC_LUI, 5'd20, 5'd0, 16'h3000));
        emit(encI(OPC_ADDIU, 5'd8, 5'd0, 16'd5));
        emit(encI(OPC_BEQ, 5'd8, 5'd8, 16'd2));
        emit(encI(OPC_ADDIU, 5'd9, 5'd0, 16'd1));
        emit(encI(OPC_ADDIU, 5'd9, 5'd9, 16'd100));
        // BEQ target at offset 5 where BNE falls through
        emit(encI(OPC_BNE, 5'd8, 5'd8, 16'd2));
        emit(encI(OPC_ADDIU, 5'd9, 5'd9, 16'd2));
        emit(encI(OPC_SW, 5'd9, 5'd20, 16'd0));
        emit(encJ(`CPU_RESET_VECTOR + 32'd44));
        emit(encI(OPC_ADDIU, 5'd9, 5'd9, 16'd4));
        emit(encI(OPC_ADDIU, 5'd9, 5'd9, 16'd1000));
        // J target at offset 11
        emit(encI(OPC_SW, 5'd9, 5'd20, 16'd4));
        emit(encI(OPC_BEQ, 5'd0, 5'd9, 16'd5));
        emit(encI(OPC_ADDIU, 5'd2, 5'd9, 16'd0));
        emit(encI(OPC_BNE, 5'd0, 5'd9, 16'd2));
        emit(encI(OPC_ADDIU, 5'd2, 5'd2, 16'd8));
        emit(encI(OPC_ADDIU, 5'd2, 5'd2, 16'd4000));
        emit(encI(OPC_SW, 5'd2, 5'd20, 16'd8));
        emitHalt();
    endtask

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b1;
        readdata    = '0;
        buildRtype();
        runProgram("rtype");
        buildItype();
        runProgram("itype");
        buildMemory();
        runProgram("loadstore");
        buildBranch();
        runProgram("branch");
        $display("%0d tests run, %0d failed, %0d errors",
                 scoreboard.testsRun, scoreboard.testsFailed, scoreboard.errorCount);
        if ((scoreboard.testsFailed == 0) && (scoreboard.testsRun == NUM_TESTS)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
